/* hdl/dbg_trigger_pkg.sv */
// Assumes 4 triggers, mcontrol6 and etrigger only, M and U privilege only; tdata3/tinfo absent
package dbg_trigger_pkg;

  //////////////////////////////////////////////////
  // Trigger count
  //////////////////////////////////////////////////

  localparam int unsigned NUM_TRIGGERS = 4;
  localparam int unsigned TSEL_W       = $clog2(NUM_TRIGGERS); // Trigger index width

  // Privilege levels seen by the match logic
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // tdata1.type encodings that are implemented
  typedef enum logic [3:0] {
    TT_ETRIGGER  = 4'd5,
    TT_MCONTROL6 = 4'd6,
    TT_DISABLED  = 4'd15
  } ttype_e;

  // Address compare rules (mcontrol6.match)
  typedef enum logic [3:0] {
    MATCH_EQ = 4'd0,                 // Equal
    MATCH_GE = 4'd2,                 // Greater or equal
    MATCH_LT = 4'd3                  // Less than
  } match_e;

  //////////////////////////////////////////////////
  // tdata1 views
  //////////////////////////////////////////////////

  // Address/data match trigger
  typedef struct packed {
    ttype_e     ttype;               // 31:28
    logic       dmode;               // 27
    logic [10:0] rsvd_26_16;         // vs, vu, hit, select, timing, size
    logic [3:0] action;              // 15:12
    logic       chain;               // 11, tied low
    match_e     match;               // 10:7
    logic       m;                   // 6
    logic [1:0] rsvd_5_4;            // S mode not present
    logic       u;                   // 3
    logic       execute;             // 2
    logic       store;               // 1
    logic       load;                // 0
  } mcontrol6_t;

  // Exception trigger
  typedef struct packed {
    ttype_e      ttype;              // 31:28
    logic        dmode;              // 27
    logic [16:0] rsvd_26_10;         // hit, vs, vu and zeros
    logic        m;                  // 9
    logic [1:0]  rsvd_8_7;           // S mode not present
    logic        u;                  // 6
    logic [5:0]  action;             // 5:0
  } etrigger_t;

  // Same 32 bits, type field shared by both views
  typedef union packed {
    mcontrol6_t mc;
    etrigger_t  et;
  } tdata1_u;

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  // Disabled trigger, dmode set
  localparam logic [31:0] TDATA1_RST = {TT_DISABLED, 1'b1, 27'd0};

  // Exception codes 0, 1, 2, 3, 5, 7, 8 and 11
  localparam logic [31:0] ETRIGGER_MASK = 32'h0000_09AF;

  // Action value for entering debug mode
  localparam int unsigned ACTION_DEBUG = 1;

endpackage

/* hdl/debug_triggers.sv */
// Debug trigger block top; CSR writes are assumed to come from debug mode only
module debug_triggers (
  input  logic                       clk,
  input  logic                       rst_n_i,

  // CSR write port
  input  logic [31:0]                csr_wdata_i,
  input  logic                       tselect_we_i,
  input  logic                       tdata1_we_i,
  input  logic                       tdata2_we_i,

  // CSR read data
  output logic [31:0]                tselect_rdata_o,
  output logic [31:0]                tdata1_rdata_o,
  output logic [31:0]                tdata2_rdata_o,

  // IF stage
  input  logic [31:0]                pc_if_i,
  input  dbg_trigger_pkg::priv_lvl_e priv_if_i,

  // EX stage LSU
  input  logic                       lsu_valid_i,
  input  logic [31:0]                lsu_addr_i,
  input  logic                       lsu_we_i,
  input  logic [3:0]                 lsu_be_i,
  input  dbg_trigger_pkg::priv_lvl_e priv_ex_i,

  // WB stage exception
  input  logic                       exc_valid_i,
  input  logic [10:0]                exc_cause_i,
  input  dbg_trigger_pkg::priv_lvl_e priv_wb_i,

  input  logic                       debug_mode_i,

  // Trigger matches
  output logic                       trigger_match_if_o,  // Instruction address
  output logic                       trigger_match_ex_o,  // Load/store address
  output logic                       etrigger_wb_o        // Exception
);

  import dbg_trigger_pkg::*;

  logic [TSEL_W-1:0]       tselect;
  tdata1_u                 tdata1_wdata;        // Resolved write data
  logic [31:0]             tdata2_wdata;
  logic [NUM_TRIGGERS-1:0] tdata1_we;
  logic [NUM_TRIGGERS-1:0] tdata2_we;
  tdata1_u                 tdata1_q [NUM_TRIGGERS];
  logic [31:0]             tdata2_q [NUM_TRIGGERS];
  tdata1_u                 sel_tdata1;          // Selected trigger, for WARL and readback
  logic [31:0]             sel_tdata2;
  logic [NUM_TRIGGERS-1:0] match_if;
  logic [NUM_TRIGGERS-1:0] match_ex;
  logic [NUM_TRIGGERS-1:0] etrig_wb;

  //////////////////////////////////////////////////
  // CSR write resolution
  //////////////////////////////////////////////////

  trigger_csr_write csr_write_i (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .csr_wdata_i    (csr_wdata_i),
    .tselect_we_i   (tselect_we_i),
    .tdata1_we_i    (tdata1_we_i),
    .tdata2_we_i    (tdata2_we_i),
    .sel_tdata1_i   (sel_tdata1),
    .sel_tdata2_i   (sel_tdata2),
    .tselect_o      (tselect),
    .tdata1_wdata_o (tdata1_wdata),
    .tdata2_wdata_o (tdata2_wdata),
    .tdata1_we_o    (tdata1_we),
    .tdata2_we_o    (tdata2_we)
  );

  // One unit per trigger
  for (genvar i = 0; i < NUM_TRIGGERS; i++) begin : gen_trig
    trigger_unit unit_i (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .tdata1_wdata_i (tdata1_wdata),
      .tdata1_we_i    (tdata1_we[i]),
      .tdata2_wdata_i (tdata2_wdata),
      .tdata2_we_i    (tdata2_we[i]),
      .pc_if_i        (pc_if_i),
      .priv_if_i      (priv_if_i),
      .lsu_valid_i    (lsu_valid_i),
      .lsu_addr_i     (lsu_addr_i),
      .lsu_we_i       (lsu_we_i),
      .lsu_be_i       (lsu_be_i),
      .priv_ex_i      (priv_ex_i),
      .exc_valid_i    (exc_valid_i),
      .exc_cause_i    (exc_cause_i),
      .priv_wb_i      (priv_wb_i),
      .debug_mode_i   (debug_mode_i),
      .tdata1_o       (tdata1_q[i]),
      .tdata2_o       (tdata2_q[i]),
      .match_if_o     (match_if[i]),
      .match_ex_o     (match_ex[i]),
      .etrig_wb_o     (etrig_wb[i])
    );
  end

  //////////////////////////////////////////////////
  // Readback and match combine
  //////////////////////////////////////////////////

  trigger_collect collect_i (
    .tselect_i          (tselect),
    .tdata1_i           (tdata1_q),
    .tdata2_i           (tdata2_q),
    .match_if_i         (match_if),
    .match_ex_i         (match_ex),
    .etrig_wb_i         (etrig_wb),
    .sel_tdata1_o       (sel_tdata1),
    .sel_tdata2_o       (sel_tdata2),
    .trigger_match_if_o (trigger_match_if_o),
    .trigger_match_ex_o (trigger_match_ex_o),
    .etrigger_wb_o      (etrigger_wb_o)
  );

  assign tselect_rdata_o = 32'(tselect);   // Zero extended index
  assign tdata1_rdata_o  = sel_tdata1;
  assign tdata2_rdata_o  = sel_tdata2;

endmodule

/* hdl/trigger_collect.sv */
// Readback mux for the selected trigger; tselect is assumed already in range
module trigger_collect (
  // Index of the selected trigger
  input  logic [dbg_trigger_pkg::TSEL_W-1:0]       tselect_i,

  // Registers of all triggers
  input  dbg_trigger_pkg::tdata1_u                 tdata1_i [dbg_trigger_pkg::NUM_TRIGGERS],
  input  logic [31:0]                              tdata2_i [dbg_trigger_pkg::NUM_TRIGGERS],

  // Per-trigger matches
  input  logic [dbg_trigger_pkg::NUM_TRIGGERS-1:0] match_if_i,
  input  logic [dbg_trigger_pkg::NUM_TRIGGERS-1:0] match_ex_i,
  input  logic [dbg_trigger_pkg::NUM_TRIGGERS-1:0] etrig_wb_i,

  // Selected registers
  output dbg_trigger_pkg::tdata1_u                 sel_tdata1_o,
  output logic [31:0]                              sel_tdata2_o,

  // Combined matches
  output logic                                     trigger_match_if_o,
  output logic                                     trigger_match_ex_o,
  output logic                                     etrigger_wb_o
);

  import dbg_trigger_pkg::*;

  //////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////

  always_comb begin
    sel_tdata1_o = tdata1_i[0];      // Default trigger 0
    sel_tdata2_o = tdata2_i[0];
    for (int i = 1; i < NUM_TRIGGERS; i++) begin
      if (tselect_i == TSEL_W'(i)) begin
        sel_tdata1_o = tdata1_i[i];
        sel_tdata2_o = tdata2_i[i];
      end
    end
  end

  // Any trigger hitting raises the stage output
  assign trigger_match_if_o = |match_if_i;
  assign trigger_match_ex_o = |match_ex_i;
  assign etrigger_wb_o      = |etrig_wb_i;

endmodule

/* hdl/trigger_csr_write.sv */
// tselect is WARL 0..NUM_TRIGGERS-1; tdata1 writes of type other than 5 or 6 resolve to disabled
module trigger_csr_write (
  input  logic                                    clk,
  input  logic                                    rst_n_i,

  // CSR write port from the core
  input  logic [31:0]                             csr_wdata_i,
  input  logic                                    tselect_we_i,
  input  logic                                    tdata1_we_i,
  input  logic                                    tdata2_we_i,

  // Registers of the selected trigger
  input  dbg_trigger_pkg::tdata1_u                sel_tdata1_i,
  input  logic [31:0]                             sel_tdata2_i,

  // Resolved write data and per-trigger enables
  output logic [dbg_trigger_pkg::TSEL_W-1:0]      tselect_o,
  output dbg_trigger_pkg::tdata1_u                tdata1_wdata_o,
  output logic [31:0]                             tdata2_wdata_o,
  output logic [dbg_trigger_pkg::NUM_TRIGGERS-1:0] tdata1_we_o,
  output logic [dbg_trigger_pkg::NUM_TRIGGERS-1:0] tdata2_we_o
);

  import dbg_trigger_pkg::*;

  logic [TSEL_W-1:0] tselect_q;
  logic              tselect_legal;   // Written index in range
  tdata1_u           wdata_view;      // Raw write data, decoded both ways
  tdata1_u           tdata1_res;      // WARL resolved tdata1
  logic              tdata2_illegal;  // Selected tdata2 has codes outside the mask

  //////////////////////////////////////////////////
  // tselect
  //////////////////////////////////////////////////

  assign tselect_legal = (csr_wdata_i < 32'(NUM_TRIGGERS));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tselect_q <= '0;
    end else if (tselect_we_i && tselect_legal) begin
      tselect_q <= csr_wdata_i[TSEL_W-1:0];  // Illegal values keep the old index
    end
  end

  assign tselect_o = tselect_q;

  //////////////////////////////////////////////////
  // tdata1 WARL
  //////////////////////////////////////////////////

  assign wdata_view     = csr_wdata_i;
  assign tdata2_illegal = |(sel_tdata2_i & ~ETRIGGER_MASK);

  always_comb begin
    tdata1_res = TDATA1_RST;                 // Default: disabled trigger
    case (wdata_view.mc.ttype)
      TT_MCONTROL6: begin
        tdata1_res            = '0;
        tdata1_res.mc.ttype   = TT_MCONTROL6;
        tdata1_res.mc.dmode   = 1'b1;        // Debug mode access only
        tdata1_res.mc.action  = 4'(ACTION_DEBUG);
        tdata1_res.mc.m       = wdata_view.mc.m;
        tdata1_res.mc.u       = wdata_view.mc.u;
        tdata1_res.mc.execute = wdata_view.mc.execute;
        tdata1_res.mc.store   = wdata_view.mc.store;
        tdata1_res.mc.load    = wdata_view.mc.load;
        // Match is WARL (0, 2, 3)
        case (wdata_view.mc.match)
          MATCH_EQ, MATCH_GE, MATCH_LT: tdata1_res.mc.match = wdata_view.mc.match;
          default:                      tdata1_res.mc.match = MATCH_EQ;
        endcase
      end
      TT_ETRIGGER: begin
        // Only accepted when tdata2 holds implemented codes
        if (!tdata2_illegal) begin
          tdata1_res           = '0;
          tdata1_res.et.ttype  = TT_ETRIGGER;
          tdata1_res.et.dmode  = 1'b1;
          tdata1_res.et.m      = wdata_view.et.m;   // Bit 9
          tdata1_res.et.u      = wdata_view.et.u;   // Bit 6
          tdata1_res.et.action = 6'(ACTION_DEBUG);
        end
      end
      default: ;                             // mcontrol type 2 and unknown types
    endcase
  end

  assign tdata1_wdata_o = tdata1_res;

  // Etrigger only holds implemented exception codes
  assign tdata2_wdata_o = (sel_tdata1_i.mc.ttype == TT_ETRIGGER) ?
                          (csr_wdata_i & ETRIGGER_MASK) : csr_wdata_i;

  // One-hot enables to the selected trigger
  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      tdata1_we_o[i] = tdata1_we_i && (tselect_q == TSEL_W'(i));
      tdata2_we_o[i] = tdata2_we_i && (tselect_q == TSEL_W'(i));
    end
  end

endmodule

/* hdl/trigger_unit.sv */
// One trigger; write data arrives already WARL resolved, all matches are combinational
module trigger_unit (
  input  logic                       clk,
  input  logic                       rst_n_i,

  // CSR write
  input  dbg_trigger_pkg::tdata1_u   tdata1_wdata_i,
  input  logic                       tdata1_we_i,
  input  logic [31:0]                tdata2_wdata_i,
  input  logic                       tdata2_we_i,

  // IF stage
  input  logic [31:0]                pc_if_i,
  input  dbg_trigger_pkg::priv_lvl_e priv_if_i,

  // EX stage LSU
  input  logic                       lsu_valid_i,
  input  logic [31:0]                lsu_addr_i,
  input  logic                       lsu_we_i,
  input  logic [3:0]                 lsu_be_i,
  input  dbg_trigger_pkg::priv_lvl_e priv_ex_i,

  // WB stage exception
  input  logic                       exc_valid_i,
  input  logic [10:0]                exc_cause_i,
  input  dbg_trigger_pkg::priv_lvl_e priv_wb_i,

  input  logic                       debug_mode_i,

  // Register contents and matches
  output dbg_trigger_pkg::tdata1_u   tdata1_o,
  output logic [31:0]                tdata2_o,
  output logic                       match_if_o,
  output logic                       match_ex_o,
  output logic                       etrig_wb_o
);

  import dbg_trigger_pkg::*;

  tdata1_u     tdata1_q;
  logic [31:0] tdata2_q;
  logic        is_mc;              // Address match trigger
  logic        is_et;              // Exception trigger
  logic        if_hit;             // PC compare result
  logic [1:0]  lsu_lo_lsb;         // Lowest accessed byte offset
  logic [1:0]  lsu_hi_lsb;         // Highest accessed byte offset
  logic        lsu_byte_hit;       // Some enabled byte at tdata2[1:0]
  logic        lsu_hit;            // LSU compare result
  logic        lsu_dir_ok;         // Load/store direction enabled
  logic        exc_hit;            // Cause bit set in tdata2

  // Privilege qualifier shared by all stages
  function automatic logic priv_ok(input logic m, input logic u, input priv_lvl_e priv);
    return (m && (priv == PRIV_M)) || (u && (priv == PRIV_U));
  endfunction

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tdata1_q <= TDATA1_RST;
      tdata2_q <= '0;
    end else begin
      if (tdata1_we_i) tdata1_q <= tdata1_wdata_i;
      if (tdata2_we_i) tdata2_q <= tdata2_wdata_i;
    end
  end

  assign tdata1_o = tdata1_q;
  assign tdata2_o = tdata2_q;

  assign is_mc = (tdata1_q.mc.ttype == TT_MCONTROL6);
  assign is_et = (tdata1_q.et.ttype == TT_ETRIGGER);

  //////////////////////////////////////////////////
  // Instruction address (IF)
  //////////////////////////////////////////////////

  always_comb begin
    case (tdata1_q.mc.match)
      MATCH_GE: if_hit = (pc_if_i >= tdata2_q);
      MATCH_LT: if_hit = (pc_if_i < tdata2_q);
      default:  if_hit = (pc_if_i == tdata2_q);
    endcase
  end

  assign match_if_o = is_mc && tdata1_q.mc.execute && if_hit && !debug_mode_i &&
                      priv_ok(tdata1_q.mc.m, tdata1_q.mc.u, priv_if_i);

  //////////////////////////////////////////////////
  // Load/store address (EX)
  //////////////////////////////////////////////////

  // Byte span of the access from the byte enables
  always_comb begin
    lsu_lo_lsb = 2'b00;
    lsu_hi_lsb = 2'b00;
    for (int b = 0; b < 4; b++) begin
      if (lsu_be_i[b]) begin
        lsu_hi_lsb = 2'(b);          // Last set bit wins
      end
    end
    for (int b = 3; b >= 0; b--) begin
      if (lsu_be_i[b]) begin
        lsu_lo_lsb = 2'(b);          // First set bit wins
      end
    end
  end

  assign lsu_byte_hit = |(lsu_be_i & (4'b0001 << tdata2_q[1:0]));

  always_comb begin
    case (tdata1_q.mc.match)
      MATCH_GE: lsu_hit = ({lsu_addr_i[31:2], lsu_hi_lsb} >= tdata2_q);
      MATCH_LT: lsu_hit = ({lsu_addr_i[31:2], lsu_lo_lsb} < tdata2_q);
      default:  lsu_hit = (lsu_addr_i[31:2] == tdata2_q[31:2]) && lsu_byte_hit;
    endcase
  end

  assign lsu_dir_ok = (tdata1_q.mc.load && !lsu_we_i) || (tdata1_q.mc.store && lsu_we_i);

  assign match_ex_o = is_mc && lsu_valid_i && lsu_dir_ok && lsu_hit && !debug_mode_i &&
                      priv_ok(tdata1_q.mc.m, tdata1_q.mc.u, priv_ex_i);

  //////////////////////////////////////////////////
  // Exception trigger (WB)
  //////////////////////////////////////////////////

  // Causes of 32 and above never hit
  assign exc_hit = exc_valid_i && (exc_cause_i < 11'd32) && tdata2_q[exc_cause_i[4:0]];

  assign etrig_wb_o = is_et && exc_hit && !debug_mode_i &&
                      priv_ok(tdata1_q.et.m, tdata1_q.et.u, priv_wb_i);

endmodule

/* project.f */
hdl/dbg_trigger_pkg.sv
hdl/trigger_csr_write.sv
hdl/trigger_unit.sv
hdl/trigger_collect.sv
hdl/debug_triggers.sv
testbench/debug_triggers_chk.sv
testbench/tb_debug_triggers.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the trigger testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_debug_triggers -f project.f \
  --Mdir obj_dir -o tb_debug_triggers
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_debug_triggers > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
fi

if grep -q "All tests passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* testbench/debug_triggers_chk.sv */
// Sampled on the rising edge; inputs are expected to settle well before it
module debug_triggers_chk (
  input logic        clk,
  input logic        rst_n_i,
  input logic        debug_mode_i,
  input logic [31:0] csr_wdata_i,
  input logic        tselect_we_i,
  input logic [31:0] tselect_rdata_i,
  input logic [31:0] tdata1_rdata_i,
  input logic        match_if_i,
  input logic        match_ex_i,
  input logic        etrig_wb_i
);

  import dbg_trigger_pkg::*;

  //////////////////////////////////////////////////
  // Invariants of the trigger block
  //////////////////////////////////////////////////

  // Every trigger starts disabled
  a_quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n_i) |-> !(match_if_i || match_ex_i || etrig_wb_i))
    else $error("Match output high right after reset");

  a_debug_mask: assert property (@(posedge clk) disable iff (!rst_n_i)
    debug_mode_i |-> !(match_if_i || match_ex_i || etrig_wb_i))   // Debug mode masks all
    else $error("Match output high in debug mode");

  // Index above NUM_TRIGGERS-1 is not taken, tselect stays where it was
  a_tselect_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    (tselect_we_i && (csr_wdata_i >= NUM_TRIGGERS)) |=> $stable(tselect_rdata_i))
    else $error("tselect moved on an out-of-range write");

  a_dmode_set: assert property (@(posedge clk) disable iff (!rst_n_i)
    tdata1_rdata_i[27])                                            // dmode bit
    else $error("tdata1 dmode bit clear");

endmodule

/* testbench/tb_debug_triggers.sv */
// Fixed-seed random run against a reference model; one CSR write per cycle, stops at first mismatch
module tb_debug_triggers;

  import dbg_trigger_pkg::*;

  localparam int RAND_CYCLES = 4000;
  localparam int MAX_CYCLES  = RAND_CYCLES + 1000;  // Random phase plus directed phase and margin
  localparam int CSR_TSEL    = 0;
  localparam int CSR_TDATA1  = 1;
  localparam int CSR_TDATA2  = 2;

  logic        clk;
  logic        rst_n;
  logic [31:0] csr_wdata;
  logic        tselect_we;
  logic        tdata1_we;
  logic        tdata2_we;
  logic [31:0] tselect_rdata;
  logic [31:0] tdata1_rdata;
  logic [31:0] tdata2_rdata;
  logic [31:0] pc_if;
  priv_lvl_e   priv_if;
  logic        lsu_valid;
  logic [31:0] lsu_addr;
  logic        lsu_we;
  logic [3:0]  lsu_be;
  priv_lvl_e   priv_ex;
  logic        exc_valid;
  logic [10:0] exc_cause;
  priv_lvl_e   priv_wb;
  logic        debug_mode;
  logic        match_if;
  logic        match_ex;
  logic        etrig_wb;

  integer seed = 32'hf86f_2952;
  int     cycles = 0;

  // Reference model state
  logic [31:0]       m_tdata1 [NUM_TRIGGERS];
  logic [31:0]       m_tdata2 [NUM_TRIGGERS];
  logic [TSEL_W-1:0] m_tsel;

  debug_triggers dut_i (
    .clk(clk), .rst_n_i(rst_n), .csr_wdata_i(csr_wdata), .tselect_we_i(tselect_we),
    .tdata1_we_i(tdata1_we), .tdata2_we_i(tdata2_we), .tselect_rdata_o(tselect_rdata),
    .tdata1_rdata_o(tdata1_rdata), .tdata2_rdata_o(tdata2_rdata), .pc_if_i(pc_if),
    .priv_if_i(priv_if), .lsu_valid_i(lsu_valid), .lsu_addr_i(lsu_addr), .lsu_we_i(lsu_we),
    .lsu_be_i(lsu_be), .priv_ex_i(priv_ex), .exc_valid_i(exc_valid), .exc_cause_i(exc_cause),
    .priv_wb_i(priv_wb), .debug_mode_i(debug_mode), .trigger_match_if_o(match_if),
    .trigger_match_ex_o(match_ex), .etrigger_wb_o(etrig_wb)
  );

  bind debug_triggers debug_triggers_chk chk_i (
    .clk(clk), .rst_n_i(rst_n_i), .debug_mode_i(debug_mode_i),
    .csr_wdata_i(csr_wdata_i), .tselect_we_i(tselect_we_i),
    .tselect_rdata_i(tselect_rdata_o), .tdata1_rdata_i(tdata1_rdata_o),
    .match_if_i(trigger_match_if_o), .match_ex_i(trigger_match_ex_o),
    .etrig_wb_i(etrigger_wb_o)
  );

  always #10 clk = ~clk;             // Period 20

  //////////////////////////////////////////////////
  // Failure reporting and timeout
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Run stopped");
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  task automatic check_tdata1(input string name, input tdata1_u exp, input tdata1_u act);
    if (act !== exp) begin
      $display("ERR %0t: %s expected %h (type %0d) got %h (type %0d)", $time, name,
               exp, exp.mc.ttype, act, act.mc.ttype);
      abort_run();
    end
  endtask

  task automatic check_csr(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_match(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t: %s expected %b got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // WARL view of a tdata1 write, built field by field
  function automatic logic [31:0] resolve_tdata1(input logic [31:0] w, input logic [31:0] t2);
    logic [3:0]  mt;
    logic [31:0] r;
    mt = w[10:7];
    r  = TDATA1_RST;                 // Type 2, 7 and anything unknown
    if (w[31:28] == 4'd6) begin
      if (mt != 4'd0 && mt != 4'd2 && mt != 4'd3) begin
        mt = 4'd0;                   // Unsupported rule falls back to equal
      end
      r = {4'd6, 1'b1, 11'd0, 4'd1, 1'b0, mt, w[6], 2'b00, w[3], w[2:0]};
    end else if (w[31:28] == 4'd5 && (t2 & ~ETRIGGER_MASK) == 32'd0) begin
      r = {4'd5, 1'b1, 17'd0, w[9], 2'b00, w[6], 6'd1};
    end
    return r;
  endfunction

  // Registers the write that was on the bus at this edge
  task automatic update_model();
    if (tselect_we && csr_wdata < NUM_TRIGGERS) begin
      m_tsel = csr_wdata[TSEL_W-1:0];
    end
    if (tdata1_we) begin
      m_tdata1[m_tsel] = resolve_tdata1(csr_wdata, m_tdata2[m_tsel]);
    end
    if (tdata2_we) begin
      m_tdata2[m_tsel] = (m_tdata1[m_tsel][31:28] == 4'd5) ? (csr_wdata & ETRIGGER_MASK)
                                                           : csr_wdata;
    end
  endtask

  task automatic predict(output logic e_if, output logic e_ex, output logic e_wb);
    logic [31:0] t1;
    logic [31:0] t2;
    logic [1:0]  lo;
    logic [1:0]  hi;
    logic        seen;
    logic        hit_if;
    logic        hit_ex;
    e_if = 1'b0;
    e_ex = 1'b0;
    e_wb = 1'b0;
    lo   = 2'd0;
    hi   = 2'd0;
    seen = 1'b0;
    for (int b = 0; b < 4; b++) begin
      if (lsu_be[b]) begin
        if (!seen) lo = 2'(b);       // Lowest enabled byte
        hi   = 2'(b);
        seen = 1'b1;
      end
    end
    for (int t = 0; t < NUM_TRIGGERS; t++) begin
      t1 = m_tdata1[t];
      t2 = m_tdata2[t];
      if (t1[31:28] == 4'd6) begin
        case (t1[10:7])
          4'd2: begin
            hit_if = pc_if >= t2;
            hit_ex = {lsu_addr[31:2], hi} >= t2;
          end
          4'd3: begin
            hit_if = pc_if < t2;
            hit_ex = {lsu_addr[31:2], lo} < t2;
          end
          default: begin
            hit_if = pc_if == t2;
            hit_ex = (lsu_addr[31:2] == t2[31:2]) && lsu_be[t2[1:0]];
          end
        endcase
        if (t1[2] && hit_if && ((t1[6] && priv_if == PRIV_M) || (t1[3] && priv_if == PRIV_U)))
          e_if = 1'b1;
        if (lsu_valid && hit_ex && ((t1[0] && !lsu_we) || (t1[1] && lsu_we)) &&
            ((t1[6] && priv_ex == PRIV_M) || (t1[3] && priv_ex == PRIV_U)))
          e_ex = 1'b1;
      end else if (t1[31:28] == 4'd5) begin
        if (exc_valid && exc_cause < 11'd32 && t2[exc_cause[4:0]] &&
            ((t1[9] && priv_wb == PRIV_M) || (t1[6] && priv_wb == PRIV_U)))
          e_wb = 1'b1;
      end
    end
    if (debug_mode) begin
      e_if = 1'b0;                   // Debug mode masks every trigger
      e_ex = 1'b0;
      e_wb = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Cycle stepping and stimulus
  //////////////////////////////////////////////////

  // Checks at the falling edge, returns at the next drive point
  task automatic next_cycle();
    logic e_if;
    logic e_ex;
    logic e_wb;
    @(negedge clk);
    predict(e_if, e_ex, e_wb);
    check_csr("tselect_rdata_o", 32'(m_tsel), tselect_rdata);
    check_tdata1("tdata1_rdata_o", m_tdata1[m_tsel], tdata1_rdata);
    check_csr("tdata2_rdata_o", m_tdata2[m_tsel], tdata2_rdata);
    check_match("trigger_match_if_o", e_if, match_if);
    check_match("trigger_match_ex_o", e_ex, match_ex);
    check_match("etrigger_wb_o", e_wb, etrig_wb);
    @(posedge clk);
    update_model();
    #2;
  endtask

  task automatic write_csr(input int kind, input logic [31:0] value);
    csr_wdata  = value;
    tselect_we = (kind == CSR_TSEL);
    tdata1_we  = (kind == CSR_TDATA1);
    tdata2_we  = (kind == CSR_TDATA2);
    next_cycle();
    tselect_we = 1'b0;
    tdata1_we  = 1'b0;
    tdata2_we  = 1'b0;
  endtask

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic drive_random();
    tselect_we = 1'b0;
    tdata1_we  = 1'b0;
    tdata2_we  = 1'b0;
    csr_wdata  = $random(seed);
    case (pick(8))
      0: begin
        tselect_we = 1'b1;
        if (pick(4) != 0) csr_wdata = pick(NUM_TRIGGERS);   // Mostly legal indices
      end
      1: begin
        tdata1_we = 1'b1;
        case (pick(4))
          0:       csr_wdata[31:28] = 4'd5;
          1:       csr_wdata[31:28] = 4'd6;
          2:       csr_wdata[31:28] = 4'd15;
          default: ;                 // Leave the random type
        endcase
      end
      2: begin
        tdata2_we = 1'b1;
        if (pick(2) == 0) csr_wdata = csr_wdata & ETRIGGER_MASK;  // Legal cause set
      end
      default: ;
    endcase
    // Addresses close to the stored compare values so that matches happen
    pc_if      = m_tdata2[pick(NUM_TRIGGERS)] + pick(9) - 32'd4;
    lsu_addr   = m_tdata2[pick(NUM_TRIGGERS)] + pick(9) - 32'd4;
    lsu_be     = 4'(pick(16));
    lsu_we     = (pick(2) == 0);
    lsu_valid  = (pick(4) != 0);
    priv_if    = (pick(2) == 0) ? PRIV_U : PRIV_M;
    priv_ex    = (pick(2) == 0) ? PRIV_U : PRIV_M;
    priv_wb    = (pick(2) == 0) ? PRIV_U : PRIV_M;
    exc_valid  = (pick(2) == 0);
    exc_cause  = (pick(8) == 0) ? 11'(pick(2048)) : 11'(pick(16));
    debug_mode = (pick(10) == 0);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    csr_wdata = '0;
    tselect_we = 1'b0;
    tdata1_we = 1'b0;
    tdata2_we = 1'b0;
    pc_if = '0;
    priv_if = PRIV_M;
    lsu_valid = 1'b0;
    lsu_addr = '0;
    lsu_we = 1'b0;
    lsu_be = '0;
    priv_ex = PRIV_M;
    exc_valid = 1'b0;
    exc_cause = '0;
    priv_wb = PRIV_M;
    debug_mode = 1'b0;
    m_tsel = '0;
    for (int t = 0; t < NUM_TRIGGERS; t++) begin
      m_tdata1[t] = TDATA1_RST;
      m_tdata2[t] = '0;
    end
    repeat (2) @(posedge clk);
    #2 rst_n = 1'b1;
    next_cycle();
    for (int t = 0; t < NUM_TRIGGERS; t++) write_csr(CSR_TSEL, 32'(t));  // Reset readback
    write_csr(CSR_TSEL, 32'd9);                  // Out of range, ignored
    write_csr(CSR_TSEL, 32'd0);
    write_csr(CSR_TDATA1, 32'h2000_0044);        // Legacy type 2
    write_csr(CSR_TDATA1, 32'h7000_0004);
    write_csr(CSR_TDATA1, 32'h6000_02CF);        // Match 5 folds to equal
    write_csr(CSR_TDATA2, 32'h0000_0100);
    pc_if = 32'h0000_0100;
    next_cycle();
    debug_mode = 1'b1;
    next_cycle();
    debug_mode = 1'b0;
    lsu_valid  = 1'b1;
    lsu_addr   = 32'h0000_0100;
    lsu_be     = 4'b0001;
    next_cycle();
    write_csr(CSR_TSEL, 32'd1);
    write_csr(CSR_TDATA2, 32'hFFFF_FFFF);
    write_csr(CSR_TDATA1, 32'h5000_0240);        // Rejected, tdata2 has unmasked codes
    write_csr(CSR_TDATA2, 32'h0000_0808);
    write_csr(CSR_TDATA1, 32'h5000_0240);
    write_csr(CSR_TDATA2, 32'hFFFF_FFFF);        // Masked on write
    exc_valid = 1'b1;
    exc_cause = 11'd3;
    priv_wb   = PRIV_U;
    next_cycle();
    exc_cause = 11'd35;                          // Above 31, never fires
    next_cycle();
    repeat (RAND_CYCLES) begin
      drive_random();
      next_cycle();
    end
    $display("All tests passed");
    $finish;
  end

endmodule
